/* uart_string_pkg.sv */
/*
 * Shared constants and state types for the UART string link.
 * Line timing, frame limits and the FSM encodings live here and are
 * referenced by scoped name from every block of the design.
 */
package uart_string_pkg;

	// line timing
	localparam int CLK_FREQ_HZ = 50_000_000;
	localparam int BAUD_RATE = 115200;
	localparam int BIT_CYCLES = CLK_FREQ_HZ / BAUD_RATE;

	// frame limits, character k sits in bits 8k+7 down to 8k
	localparam int LEN_W = 8;
	localparam logic [LEN_W-1:0] MAX_CHARS = 8'd137;
	localparam int STR_W = 8 * MAX_CHARS;

	// ascii ampersand opens and closes a frame
	localparam logic [7:0] DELIM = 8'h26;

	typedef enum logic [2:0] {
		TXF_IDLE,
		TXF_LEAD1,
		TXF_LEAD2,
		TXF_CONTENT,
		TXF_TRAIL1,
		TXF_TRAIL2
	} tx_frame_state_t;

	typedef enum logic [1:0] {
		RXF_HUNT,
		RXF_LEAD2,
		RXF_CONTENT,
		RXF_TRAIL2
	} rx_frame_state_t;

	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_START,
		LINE_DATA,
		LINE_STOP
	} line_state_t;

endpackage

/* uart_byte_if.sv */
/*
 * Byte transfer between the line blocks and the framing blocks.
 * The transmit half is used by the serializer and framer, the receive
 * half by the byte receiver and deframer.
 */
`timescale 1ns/1ps

interface uart_byte_if;

	// transmit half
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_done;

	// receive half, one pulse per byte
	logic [7:0] rx_data;
	logic rx_vld;
	logic rx_err;

	modport phy (input tx_data, input tx_start, output tx_done,
		output rx_data, output rx_vld, output rx_err);

	modport framer (output tx_data, output tx_start, input tx_done,
		input rx_data, input rx_vld, input rx_err);

endinterface

/* uart_tx_phy.sv */
/*
 * Byte serializer, 8N1.
 * Takes a byte on tx_start, drives start bit, eight data bits LSB first
 * and a stop bit, each for BIT_CYCLES clocks, then pulses tx_done.
 */
`timescale 1ns/1ps

module uart_tx_phy (
	input logic sys_clk,
	input logic sys_rst_n,
	uart_byte_if.phy byte_bus,
	output logic uart_tx_port
);

	uart_string_pkg::line_state_t state;
	logic [$clog2(uart_string_pkg::BIT_CYCLES)-1:0] bit_cnt;
	logic [2:0] bit_idx;
	logic [7:0] tx_byte;
	logic bit_end;

	assign bit_end = (bit_cnt == uart_string_pkg::BIT_CYCLES - 1);

	// last cycle of the stop bit
	assign byte_bus.tx_done = (state == uart_string_pkg::LINE_STOP) && bit_end;

	always_ff @(posedge sys_clk) begin
		if (byte_bus.tx_start)
			tx_byte <= byte_bus.tx_data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_string_pkg::LINE_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			uart_tx_port <= 1'b1;
		end else begin
			// bit period counter runs whenever a byte is on the line
			if (state == uart_string_pkg::LINE_IDLE || bit_end)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;

			case (state)
				uart_string_pkg::LINE_IDLE: begin
					if (byte_bus.tx_start) begin
						state <= uart_string_pkg::LINE_START;
						uart_tx_port <= 1'b0;
					end
				end
				uart_string_pkg::LINE_START: begin
					if (bit_end) begin
						state <= uart_string_pkg::LINE_DATA;
						bit_idx <= '0;
						uart_tx_port <= tx_byte[0];
					end
				end
				uart_string_pkg::LINE_DATA: begin
					if (bit_end && bit_idx == 3'd7) begin
						state <= uart_string_pkg::LINE_STOP;
						uart_tx_port <= 1'b1;
					end else if (bit_end) begin
						bit_idx <= bit_idx + 3'd1;
						uart_tx_port <= tx_byte[bit_idx + 3'd1];
					end
				end
				default: begin
					if (bit_end)
						state <= uart_string_pkg::LINE_IDLE;
				end
			endcase
		end
	end

	// framer must wait for tx_done before the next byte
	a_start_when_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_bus.tx_start |-> state == uart_string_pkg::LINE_IDLE);

endmodule

/* uart_rx_phy.sv */
/*
 * Byte receiver, 8N1.
 * Synchronizes the line, confirms the start bit at half a bit period and
 * samples data and stop bits at mid-bit. Emits rx_vld with the byte, or
 * rx_err when the stop bit reads low.
 */
`timescale 1ns/1ps

module uart_rx_phy (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic uart_rx_port,
	uart_byte_if.phy byte_bus
);

	uart_string_pkg::line_state_t state;
	logic [$clog2(uart_string_pkg::BIT_CYCLES)-1:0] bit_cnt;
	logic [2:0] bit_idx;
	logic [7:0] rx_shift;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic fall;
	logic sample;

	assign fall = rx_prev && !rx_sync;
	assign byte_bus.rx_data = rx_shift;

	// start bit checked at half period and later bits one full period on
	assign sample = (state == uart_string_pkg::LINE_START) ?
		(bit_cnt == uart_string_pkg::BIT_CYCLES / 2 - 1) :
		(bit_cnt == uart_string_pkg::BIT_CYCLES - 1);

	always_ff @(posedge sys_clk) begin
		if (state == uart_string_pkg::LINE_DATA && sample)
			rx_shift <= {rx_sync, rx_shift[7:1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state <= uart_string_pkg::LINE_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			byte_bus.rx_vld <= 1'b0;
			byte_bus.rx_err <= 1'b0;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			byte_bus.rx_vld <= 1'b0;
			byte_bus.rx_err <= 1'b0;

			if (state == uart_string_pkg::LINE_IDLE || sample)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;

			case (state)
				// needs a high-to-low edge so after a bad stop bit the line
				// has to go high again first
				uart_string_pkg::LINE_IDLE: begin
					if (fall)
						state <= uart_string_pkg::LINE_START;
				end
				uart_string_pkg::LINE_START: begin
					if (sample) begin
						bit_idx <= '0;
						state <= rx_sync ? uart_string_pkg::LINE_IDLE :
							uart_string_pkg::LINE_DATA;
					end
				end
				uart_string_pkg::LINE_DATA: begin
					if (sample) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= uart_string_pkg::LINE_STOP;
					end
				end
				default: begin
					if (sample) begin
						byte_bus.rx_vld <= rx_sync;
						byte_bus.rx_err <= !rx_sync;
						state <= uart_string_pkg::LINE_IDLE;
					end
				end
			endcase
		end
	end

endmodule

/* frame_tx.sv */
/*
 * Transmit framer.
 * Latches a string and length on tx_req and feeds the serializer with
 * "&&", the content characters lowest byte first, and "&&".
 */
`timescale 1ns/1ps

module frame_tx (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic [uart_string_pkg::STR_W-1:0] tx_string,
	input logic [uart_string_pkg::LEN_W-1:0] tx_length,
	input logic tx_req,
	output logic tx_busy,
	output logic tx_done,
	uart_byte_if.framer byte_bus
);

	uart_string_pkg::tx_frame_state_t state;
	logic [uart_string_pkg::STR_W-1:0] str_q;
	logic [uart_string_pkg::LEN_W-1:0] len_q;
	logic [uart_string_pkg::LEN_W-1:0] char_idx;
	logic accept;
	logic send_char;

	assign accept = tx_req && (state == uart_string_pkg::TXF_IDLE);
	assign tx_busy = (state != uart_string_pkg::TXF_IDLE);
	assign tx_done = (state == uart_string_pkg::TXF_TRAIL2) && byte_bus.tx_done;

	// next byte out is a content character
	assign send_char = byte_bus.tx_done &&
		((state == uart_string_pkg::TXF_LEAD2 && len_q != '0) ||
		(state == uart_string_pkg::TXF_CONTENT && char_idx != len_q));

	// content is shifted down so the next character is always in the low byte
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q <= tx_string;
			len_q <= (tx_length > uart_string_pkg::MAX_CHARS) ?
				uart_string_pkg::MAX_CHARS : tx_length;
			byte_bus.tx_data <= uart_string_pkg::DELIM;
		end else if (send_char) begin
			byte_bus.tx_data <= str_q[7:0];
			str_q <= str_q >> 8;
		end else if (byte_bus.tx_done) begin
			byte_bus.tx_data <= uart_string_pkg::DELIM;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_string_pkg::TXF_IDLE;
			char_idx <= '0;
			byte_bus.tx_start <= 1'b0;
		end else begin
			// one start per accepted request or finished byte, except the last
			byte_bus.tx_start <= accept ||
				(byte_bus.tx_done && state != uart_string_pkg::TXF_TRAIL2);
			if (send_char)
				char_idx <= (state == uart_string_pkg::TXF_LEAD2) ? 8'd1 : char_idx + 8'd1;

			case (state)
				uart_string_pkg::TXF_IDLE:
					if (accept) state <= uart_string_pkg::TXF_LEAD1;
				uart_string_pkg::TXF_LEAD1:
					if (byte_bus.tx_done) state <= uart_string_pkg::TXF_LEAD2;
				uart_string_pkg::TXF_LEAD2, uart_string_pkg::TXF_CONTENT:
					if (byte_bus.tx_done)
						state <= send_char ? uart_string_pkg::TXF_CONTENT :
							uart_string_pkg::TXF_TRAIL1;
				uart_string_pkg::TXF_TRAIL1:
					if (byte_bus.tx_done) state <= uart_string_pkg::TXF_TRAIL2;
				default:
					if (byte_bus.tx_done) state <= uart_string_pkg::TXF_IDLE;
			endcase
		end
	end

	a_no_req_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |-> !tx_busy);

endmodule

/* frame_rx.sv */
/*
 * Receive deframer.
 * Hunts the byte stream for "&&", collects content up to the closing "&&"
 * and publishes string and length with a one-cycle rx_done.
 * Line errors and oversized frames drop the frame.
 */
`timescale 1ns/1ps

module frame_rx (
	input logic sys_clk,
	input logic sys_rst_n,
	uart_byte_if.framer byte_bus,
	output logic [uart_string_pkg::STR_W-1:0] rx_string,
	output logic [uart_string_pkg::LEN_W-1:0] rx_length,
	output logic rx_busy,
	output logic rx_done
);

	uart_string_pkg::rx_frame_state_t state;
	logic [uart_string_pkg::STR_W-1:0] collect;
	logic [uart_string_pkg::LEN_W-1:0] char_cnt;
	logic is_delim;
	logic is_char;
	logic open_frame;
	logic store;

	assign is_delim = byte_bus.rx_vld && (byte_bus.rx_data == uart_string_pkg::DELIM);
	assign is_char = byte_bus.rx_vld && (byte_bus.rx_data != uart_string_pkg::DELIM);
	assign rx_busy = (state != uart_string_pkg::RXF_HUNT);

	assign open_frame = (state == uart_string_pkg::RXF_LEAD2) && is_delim;
	assign store = (state == uart_string_pkg::RXF_CONTENT) && is_char &&
		(char_cnt != uart_string_pkg::MAX_CHARS);

	// cleared on open so unused high bytes read zero once published
	always_ff @(posedge sys_clk) begin
		if (open_frame)
			collect <= '0;
		else if (store)
			collect[char_cnt * 8 +: 8] <= byte_bus.rx_data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_string_pkg::RXF_HUNT;
			char_cnt <= '0;
			rx_done <= 1'b0;
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			rx_done <= 1'b0;

			if (open_frame)
				char_cnt <= '0;
			else if (store)
				char_cnt <= char_cnt + 8'd1;

			if (byte_bus.rx_err) begin
				state <= uart_string_pkg::RXF_HUNT;
			end else begin
				case (state)
					uart_string_pkg::RXF_HUNT: begin
						if (is_delim)
							state <= uart_string_pkg::RXF_LEAD2;
					end
					uart_string_pkg::RXF_LEAD2: begin
						if (is_delim)
							state <= uart_string_pkg::RXF_CONTENT;
						else if (is_char)
							state <= uart_string_pkg::RXF_HUNT;
					end
					uart_string_pkg::RXF_CONTENT: begin
						if (is_delim)
							state <= uart_string_pkg::RXF_TRAIL2;
						// one character too many
						else if (is_char && !store)
							state <= uart_string_pkg::RXF_HUNT;
					end
					default: begin
						if (is_delim) begin
							rx_string <= collect;
							rx_length <= char_cnt;
							rx_done <= 1'b1;
						end
						if (byte_bus.rx_vld)
							state <= uart_string_pkg::RXF_HUNT;
					end
				endcase
			end
		end
	end

endmodule

/* uart_string_top.sv */
/*
 * UART string link top level.
 * Wires the transmit path (framer, serializer) and the receive path
 * (byte receiver, deframer) to the user and line ports.
 */
`timescale 1ns/1ps

module uart_string_top (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic [uart_string_pkg::STR_W-1:0] tx_string,
	input logic [uart_string_pkg::LEN_W-1:0] tx_length,
	input logic tx_req,
	output logic tx_busy,
	output logic tx_done,
	output logic [uart_string_pkg::STR_W-1:0] rx_string,
	output logic [uart_string_pkg::LEN_W-1:0] rx_length,
	output logic rx_busy,
	output logic rx_done,
	input logic uart_rx_port,
	output logic uart_tx_port
);

	uart_byte_if byte_bus ();

	// transmit path
	frame_tx u_frame_tx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_string(tx_string),
		.tx_length(tx_length),
		.tx_req(tx_req),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.byte_bus(byte_bus.framer)
	);

	uart_tx_phy u_uart_tx_phy (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.byte_bus(byte_bus.phy),
		.uart_tx_port(uart_tx_port)
	);

	// receive path
	uart_rx_phy u_uart_rx_phy (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.uart_rx_port(uart_rx_port),
		.byte_bus(byte_bus.phy)
	);

	frame_rx u_frame_rx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.byte_bus(byte_bus.framer),
		.rx_string(rx_string),
		.rx_length(rx_length),
		.rx_busy(rx_busy),
		.rx_done(rx_done)
	);

endmodule

/* tb_uart_string.sv */
/*
 * Self-checking testbench for the UART string link.
 * Frames go through the DUT in loopback, then hand-built byte streams
 * are driven on the receive line. Assertions check every result.
 */
`timescale 1ns/1ps

module tb_uart_string;

	// bytes on the line over all tests, longest random frame included
	localparam int PLANNED_BYTES = 335;
	localparam int CYCLE_LIMIT = PLANNED_BYTES * 10 * uart_string_pkg::BIT_CYCLES * 12 / 10;

	logic sys_clk = 1'b0;
	logic sys_rst_n;
	logic [uart_string_pkg::STR_W-1:0] tx_string;
	logic [uart_string_pkg::LEN_W-1:0] tx_length;
	logic tx_req;
	logic tx_busy;
	logic tx_done;
	logic [uart_string_pkg::STR_W-1:0] rx_string;
	logic [uart_string_pkg::LEN_W-1:0] rx_length;
	logic rx_busy;
	logic rx_done;
	logic uart_rx_port;
	logic uart_tx_port;

	integer seed = 36990;
	int cycle_cnt = 0;
	int tx_done_cnt = 0;
	int rx_done_cnt = 0;
	int exp_rx_cnt = 0;
	logic loopback;
	logic drv_line;
	logic [uart_string_pkg::STR_W-1:0] exp_string;
	logic [uart_string_pkg::LEN_W-1:0] exp_length;
	logic [7:0] tx_bytes[$];
	logic [7:0] line_bytes[$];

	// loopback switch on the receive line
	assign uart_rx_port = loopback ? uart_tx_port : drv_line;

	uart_string_top uut (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_string(tx_string),
		.tx_length(tx_length),
		.tx_req(tx_req),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.rx_string(rx_string),
		.rx_length(rx_length),
		.rx_busy(rx_busy),
		.rx_done(rx_done),
		.uart_rx_port(uart_rx_port),
		.uart_tx_port(uart_tx_port)
	);

	always #10 sys_clk = ~sys_clk;

	task automatic fail_value(input string name, input logic [uart_string_pkg::STR_W-1:0] exp_val,
		input logic [uart_string_pkg::STR_W-1:0] act_val);
		$display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp_val, act_val);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic fail_text(input string what);
		$display("error at %0t: %s", $time, what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// printable characters from 0x27 up, so never an ampersand
	function automatic logic [7:0] random_char();
		return 8'h27 + (($random(seed) & 32'h7fff_ffff) % 88);
	endfunction

	function automatic logic [uart_string_pkg::STR_W-1:0] random_string(input int len);
		logic [uart_string_pkg::STR_W-1:0] s;
		s = '0;
		for (int k = 0; k < len; k++)
			s[8*k +: 8] = random_char();
		return s;
	endfunction

	// bytes past the length read zero on the receive side
	function automatic logic [uart_string_pkg::STR_W-1:0] used_bytes(
		input logic [uart_string_pkg::STR_W-1:0] s, input int len);
		logic [uart_string_pkg::STR_W-1:0] r;
		r = '0;
		for (int k = 0; k < len; k++)
			r[8*k +: 8] = s[8*k +: 8];
		return r;
	endfunction

	task automatic expect_rx(input logic [uart_string_pkg::STR_W-1:0] str, input int len);
		exp_string = used_bytes(str, len);
		exp_length = len[uart_string_pkg::LEN_W-1:0];
		exp_rx_cnt = exp_rx_cnt + 1;
	endtask

	task automatic wait_rx();
		while (rx_done_cnt != exp_rx_cnt)
			@(posedge sys_clk);
	endtask

	task automatic queue_frame(input logic [uart_string_pkg::STR_W-1:0] str, input int len);
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(uart_string_pkg::DELIM);
		for (int k = 0; k < len; k++)
			line_bytes.push_back(str[8*k +: 8]);
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(uart_string_pkg::DELIM);
	endtask

	task automatic drive_byte(input logic [7:0] b, input logic bad_stop);
		drv_line <= 1'b0;
		repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			drv_line <= b[i];
			repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
		end
		drv_line <= !bad_stop;
		repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
		// receiver needs a high line again before the next start bit
		if (bad_stop) begin
			drv_line <= 1'b1;
			repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
		end
	endtask

	task automatic drive_line_bytes(input int bad_idx);
		for (int i = 0; i < line_bytes.size(); i++)
			drive_byte(line_bytes[i], i == bad_idx);
		line_bytes.delete();
	endtask

	task automatic send_frame(input logic [uart_string_pkg::STR_W-1:0] str, input int len);
		int start_cnt;
		logic [7:0] exp_byte;
		start_cnt = tx_done_cnt;
		tx_bytes.delete();
		expect_rx(str, len);
		@(posedge sys_clk);
		tx_string <= str;
		tx_length <= len[uart_string_pkg::LEN_W-1:0];
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		while (tx_done_cnt == start_cnt)
			@(posedge sys_clk);
		repeat (2) @(posedge sys_clk);
		assert (tx_done_cnt == start_cnt + 1)
			else fail_value("tx_done pulses", start_cnt + 1, tx_done_cnt);
		assert (tx_bytes.size() == len + 4)
			else fail_value("uart_tx_port byte count", len + 4, tx_bytes.size());
		for (int k = 0; k < len + 4; k++) begin
			if (k < 2 || k >= len + 2)
				exp_byte = uart_string_pkg::DELIM;
			else
				exp_byte = str[8*(k-2) +: 8];
			assert (tx_bytes[k] == exp_byte)
				else fail_value("uart_tx_port byte", exp_byte, tx_bytes[k]);
		end
		wait_rx();
	endtask

	// mid-bit line decoder on the transmit line
	initial begin : line_decoder
		logic [7:0] b;
		forever begin
			@(posedge sys_clk);
			if (sys_rst_n === 1'b1 && uart_tx_port === 1'b0) begin
				repeat (uart_string_pkg::BIT_CYCLES / 2) @(posedge sys_clk);
				assert (uart_tx_port == 1'b0)
					else fail_text("start bit on uart_tx_port did not hold low");
				for (int i = 0; i < 8; i++) begin
					repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
					b[i] = uart_tx_port;
				end
				repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
				assert (uart_tx_port == 1'b1)
					else fail_text("stop bit on uart_tx_port was low");
				tx_bytes.push_back(b);
			end
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT)
			fail_text("timeout, the tests did not finish within the cycle limit");
	end

	always @(posedge sys_clk) begin
		if (sys_rst_n && tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
	end

	always @(posedge sys_clk) begin
		if (sys_rst_n && rx_done) begin
			assert (rx_done_cnt < exp_rx_cnt)
				else fail_text("rx_done pulsed without a valid frame on the line");
			assert (rx_length == exp_length)
				else fail_value("rx_length", exp_length, rx_length);
			assert (rx_string == exp_string)
				else fail_value("rx_string", exp_string, rx_string);
			rx_done_cnt <= rx_done_cnt + 1;
		end
	end

	// busy from the cycle after an accepted request through tx_done
	a_busy_rise: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_req && !tx_busy) |=> tx_busy) else fail_value("tx_busy", 1'b1, tx_busy);
	a_busy_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_busy && !tx_done) |=> tx_busy) else fail_value("tx_busy", 1'b1, tx_busy);
	a_done_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> tx_busy) else fail_text("tx_done pulsed while tx_busy was low");
	a_busy_fall: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_busy) else fail_value("tx_busy", 1'b0, tx_busy);
	a_rx_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!rx_done |-> ($stable(rx_string) && $stable(rx_length)))
		else fail_text("published rx_string or rx_length changed without rx_done");

	initial begin : stimulus
		logic [uart_string_pkg::STR_W-1:0] s;
		logic [uart_string_pkg::STR_W-1:0] prev_string;
		logic [uart_string_pkg::LEN_W-1:0] prev_length;
		int len;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		loopback = 1'b1;
		drv_line = 1'b1;
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		assert (!tx_busy && !tx_done && !rx_busy && !rx_done && uart_tx_port)
			else fail_text("outputs not at their idle values after reset");

		// loopback frames, random, maximum length and empty
		len = 1 + (($random(seed) & 32'h7fff_ffff) % 20);
		send_frame(random_string(len), len);
		send_frame(random_string(137), 137);
		send_frame(random_string(10), 0);

		@(posedge sys_clk);
		loopback <= 1'b0;
		repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);

		// lone ampersand and a letter ahead of a valid frame
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(8'h41);
		s = random_string(5);
		queue_frame(s, 5);
		expect_rx(s, 5);
		drive_line_bytes(-1);
		wait_rx();

		// content byte with a low stop bit drops the frame
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(random_char());
		line_bytes.push_back(random_char());
		drive_line_bytes(-1);
		assert (rx_busy) else fail_value("rx_busy", 1'b1, rx_busy);
		line_bytes.push_back(random_char());
		drive_line_bytes(0);
		assert (!rx_busy) else fail_value("rx_busy", 1'b0, rx_busy);
		s = random_string(4);
		queue_frame(s, 4);
		expect_rx(s, 4);
		drive_line_bytes(-1);
		wait_rx();

		// one character past the limit
		prev_string = rx_string;
		prev_length = rx_length;
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(uart_string_pkg::DELIM);
		repeat (138) line_bytes.push_back(random_char());
		line_bytes.push_back(uart_string_pkg::DELIM);
		line_bytes.push_back(uart_string_pkg::DELIM);
		drive_line_bytes(-1);
		repeat (uart_string_pkg::BIT_CYCLES) @(posedge sys_clk);
		assert (rx_done_cnt == exp_rx_cnt)
			else fail_text("oversized frame produced rx_done");
		assert (rx_length == prev_length) else fail_value("rx_length", prev_length, rx_length);
		assert (rx_string == prev_string) else fail_value("rx_string", prev_string, rx_string);
		assert (tx_done_cnt == 3) else fail_value("tx_done pulses", 3, tx_done_cnt);

		$display("Test OK");
		$finish;
	end

endmodule

/* uart_string.f */
uart_string_pkg.sv
uart_byte_if.sv
uart_tx_phy.sv
uart_rx_phy.sv
frame_tx.sv
frame_rx.sv
uart_string_top.sv
tb_uart_string.sv
